// ==== Makefile ====
# Verilator build and run of the cpu cache testbench

TOP := cpu_cache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): cpu_cache.f verilog/*.sv verilog/*.svh dv/*.sv dv/*.svh
	verilator --binary --timing --assert -f cpu_cache.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "result: failed"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "result: run did not finish"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf obj_dir sim.log

// ==== cpu_cache.f ====
+incdir+verilog
+incdir+dv
verilog/cache_pkg.sv
verilog/line_cache.sv
verilog/cache_steer.sv
verilog/cpu_cache.sv
dv/cpu_cache_tb.sv

// ==== dv/cache_vectors.svh ====
// directed stimulus table for the cpu cache testbench, loaded by load_vectors
// columns: name, op, space, tag, line, word, then din, din64, expected hit, expected dout
// space 1 is program space, 0 is data space; dout is only compared on an expected hit
`ifndef CACHE_VECTORS_SVH
`define CACHE_VECTORS_SVH

function automatic void load_vectors();
   // nothing is valid straight after reset
   add_row("cold_prog", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   add_row("cold_data", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // program fill, all four words back
   add_row("fill_prog_l3", OP_FILL, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h4444_3333_2222_1111, 1'b0, 16'h0000);
   add_row("prog_l3_w0", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b1, 16'h1111);
   add_row("prog_l3_w1", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b1, 16'h2222);
   add_row("prog_l3_w2", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd2,
           16'h0000, 64'h0, 1'b1, 16'h3333);
   add_row("prog_l3_w3", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd3,
           16'h0000, 64'h0, 1'b1, 16'h4444);
   // same line index, other tag
   add_row("prog_l3_tag_miss", OP_READ, 1'b1, 16'h1235, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // program line is not seen from data space
   add_row("data_l3_space_miss", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // and a data line is not seen from program space
   add_row("fill_data_l7", OP_FILL, 1'b0, 16'h0abc, 5'd7, 2'd0,
           16'h0000, 64'hdddd_cccc_bbbb_aaaa, 1'b0, 16'h0000);
   add_row("data_l7_w2", OP_READ, 1'b0, 16'h0abc, 5'd7, 2'd2,
           16'h0000, 64'h0, 1'b1, 16'hcccc);
   add_row("prog_l7_space_miss", OP_READ, 1'b1, 16'h0abc, 5'd7, 2'd2,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // write hits only the program cache here
   add_row("write_l3_w2", OP_WRITE, 1'b0, 16'h1234, 5'd3, 2'd2,
           16'h5a5a, 64'h0, 1'b0, 16'h0000);
   add_row("prog_l3_w2_merged", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd2,
           16'h0000, 64'h0, 1'b1, 16'h5a5a);
   add_row("prog_l3_w1_kept", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b1, 16'h2222);
   // now both caches hold tag 1234 on line 3
   add_row("fill_data_l3", OP_FILL, 1'b0, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h8888_7777_6666_5555, 1'b0, 16'h0000);
   add_row("write_l3_w0_both", OP_WRITE, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0f0f, 64'h0, 1'b0, 16'h0000);
   add_row("data_l3_w0_merged", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b1, 16'h0f0f);
   add_row("prog_l3_w0_merged", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b1, 16'h0f0f);
   add_row("data_l3_w1_kept", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b1, 16'h6666);
   add_row("data_l3_w2_fill", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd2,
           16'h0000, 64'h0, 1'b1, 16'h7777);
   // write miss in both caches
   add_row("write_miss_l3", OP_WRITE, 1'b1, 16'h2222, 5'd3, 2'd1,
           16'hdead, 64'h0, 1'b0, 16'h0000);
   add_row("prog_l3_w1_after_miss", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b1, 16'h2222);
   add_row("data_l3_w1_after_miss", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b1, 16'h6666);
   add_row("data_miss_tag_2222", OP_READ, 1'b0, 16'h2222, 5'd3, 2'd1,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // flush drops every line
   add_row("flush_all", OP_FLUSH, 1'b0, 16'h0000, 5'd0, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   add_row("prog_l3_flushed", OP_READ, 1'b1, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   add_row("data_l3_flushed", OP_READ, 1'b0, 16'h1234, 5'd3, 2'd0,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   add_row("data_l7_flushed", OP_READ, 1'b0, 16'h0abc, 5'd7, 2'd2,
           16'h0000, 64'h0, 1'b0, 16'h0000);
   // top line index, refilled after the flush
   add_row("fill_prog_l31", OP_FILL, 1'b1, 16'h0042, 5'd31, 2'd0,
           16'h0000, 64'h0123_4567_89ab_cdef, 1'b0, 16'h0000);
   add_row("prog_l31_w3", OP_READ, 1'b1, 16'h0042, 5'd31, 2'd3,
           16'h0000, 64'h0, 1'b1, 16'h0123);
endfunction

`endif

// ==== dv/cpu_cache_tb.sv ====
// testbench for cpu_cache: reset sweep, directed table, random traffic against a reference model
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cpu_cache_tb;

   import cache_pkg::*;

   // operation codes of the stimulus table
   localparam logic [1:0] OP_FILL  = 2'd0;
   localparam logic [1:0] OP_READ  = 2'd1;
   localparam logic [1:0] OP_WRITE = 2'd2;
   localparam logic [1:0] OP_FLUSH = 2'd3;

   // operations in the random section
   localparam int RAND_COUNT = 400;

   // DUT inputs
   logic        clk_128;
   logic        arst_n;
   logic        flush;
   cpu_addr_u   addr;
   logic        space;
   logic        rd;
   logic        wr;
   logic [15:0] din;
   logic [63:0] din64;
   logic        update64;

   // DUT outputs
   wire [15:0]                  dout;
   wire                         hit;
   wire [`CACHE_COUNT_BITS-1:0] hit_count;
   wire [`CACHE_COUNT_BITS-1:0] miss_count;

   // table rows, one queue per column
   string       row_name [$];
   logic [1:0]  row_op   [$];
   logic        row_space[$];
   cpu_addr_u   row_addr [$];
   logic [15:0] row_din  [$];
   logic [63:0] row_din64[$];
   logic        row_hit  [$];
   logic [15:0] row_dout [$];

   // reference model, indexed by space then line
   logic [LINE_COUNT-1:0] ref_valid [2];
   logic [TAG_BITS-1:0]   ref_tag   [2][LINE_COUNT];
   line_data_u            ref_data  [2][LINE_COUNT];

   // own tally of reads and errors
   int error_count;
   int read_hits;
   int read_misses;

   // run length guard
   int cycle_count;
   int cycle_limit = 100;

   cpu_cache dut0 (
      .clk_128    (clk_128),
      .arst_n     (arst_n),
      .flush      (flush),
      .addr       (addr),
      .space      (space),
      .rd         (rd),
      .wr         (wr),
      .din        (din),
      .din64      (din64),
      .update64   (update64),
      .dout       (dout),
      .hit        (hit),
      .hit_count  (hit_count),
      .miss_count (miss_count)
   );

   // build a word address from its tag, line and word fields
   function automatic cpu_addr_u make_addr(
      input logic [TAG_BITS-1:0]         tag,
      input logic [`CACHE_LINE_BITS-1:0] line,
      input logic [1:0]                  word
   );
      cpu_addr_u a;
      a.field.tag  = tag;
      a.field.line = line;
      a.field.word = word;
      return a;
   endfunction

   function automatic void add_row(
      input string                       name,
      input logic [1:0]                  op,
      input logic                        sp,
      input logic [TAG_BITS-1:0]         tag,
      input logic [`CACHE_LINE_BITS-1:0] line,
      input logic [1:0]                  word,
      input logic [15:0]                 wdata,
      input logic [63:0]                 ldata,
      input logic                        exp_h,
      input logic [15:0]                 exp_d
   );
      row_name.push_back(name);
      row_op.push_back(op);
      row_space.push_back(sp);
      row_addr.push_back(make_addr(tag, line, word));
      row_din.push_back(wdata);
      row_din64.push_back(ldata);
      row_hit.push_back(exp_h);
      row_dout.push_back(exp_d);
   endfunction

   `include "cache_vectors.svh"

   // all strobes low, buses parked at zero
   function automatic void clear_inputs();
      flush    = 1'b0;
      addr     = '0;
      space    = 1'b0;
      rd       = 1'b0;
      wr       = 1'b0;
      din      = 16'h0000;
      din64    = 64'h0;
      update64 = 1'b0;
   endfunction

   function automatic void clear_model();
      ref_valid[1'b0] = '0;
      ref_valid[1'b1] = '0;
   endfunction

   // a write lands in one space only where that space holds the line
   function automatic void merge_word(input logic sp, input cpu_addr_u a, input logic [15:0] w);
      if (ref_valid[sp][a.field.line] && ref_tag[sp][a.field.line] == a.field.tag) begin
         ref_data[sp][a.field.line].word[a.field.word] = w;
      end
   endfunction

   function automatic void update_model(
      input logic [1:0]  op,
      input logic        sp,
      input cpu_addr_u   a,
      input logic [15:0] wdata,
      input logic [63:0] ldata
   );
      case (op)
         OP_FILL: begin
            ref_valid[sp][a.field.line]     = 1'b1;
            ref_tag[sp][a.field.line]       = a.field.tag;
            ref_data[sp][a.field.line].flat = ldata;
         end
         OP_WRITE: begin
            // cpu writes reach both caches
            merge_word(1'b0, a, wdata);
            merge_word(1'b1, a, wdata);
         end
         OP_FLUSH: begin
            clear_model();
         end
         default: begin
         end
      endcase
   endfunction

   function automatic void predict_read(
      input  logic        sp,
      input  cpu_addr_u   a,
      output logic        exp_h,
      output logic [15:0] exp_d
   );
      exp_h = ref_valid[sp][a.field.line] && (ref_tag[sp][a.field.line] == a.field.tag);
      exp_d = ref_data[sp][a.field.line].word[a.field.word];
   endfunction

   task automatic check_read(input string name, input logic exp_h, input logic [15:0] exp_d);
      if (hit !== exp_h) begin
         error_count++;
         $display("[ERROR] %s: hit expected %0b actual %0b", name, exp_h, hit);
      end
      // a miss leaves dout undefined
      if (exp_h && dout !== exp_d) begin
         error_count++;
         $display("[ERROR] %s: dout expected %h actual %h", name, exp_d, dout);
      end
   endtask

   task automatic check_count(
      input string                       name,
      input int                          exp,
      input logic [`CACHE_COUNT_BITS-1:0] act
   );
      // the run stays far below the saturation point
      if (act !== `CACHE_COUNT_BITS'(exp)) begin
         error_count++;
         $display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic drive_idle();
      @(posedge clk_128);
      #1;
      clear_inputs();
   endtask

   // drive one operation 1 ns after the edge, it is taken at the next edge
   // a read is checked 1 ns later while the lookup is still in the same cycle
   task automatic run_op(
      input string       name,
      input logic [1:0]  op,
      input logic        sp,
      input cpu_addr_u   a,
      input logic [15:0] wdata,
      input logic [63:0] ldata,
      input logic        exp_h,
      input logic [15:0] exp_d
   );
      @(posedge clk_128);
      #1;
      addr     = a;
      space    = sp;
      din      = wdata;
      din64    = ldata;
      rd       = (op == OP_READ);
      wr       = (op == OP_WRITE);
      update64 = (op == OP_FILL);
      flush    = (op == OP_FLUSH);
      if (op == OP_READ) begin
         #1;
         check_read(name, exp_h, exp_d);
         if (exp_h) begin
            read_hits++;
         end else begin
            read_misses++;
         end
      end
      update_model(op, sp, a, wdata, ldata);
   endtask

   // random fills, writes, reads and the odd flush over both spaces
   // four tags on four lines, so hits and conflicts both come up often
   task automatic run_random_traffic();
      logic [31:0] r;
      int          pick;
      logic [1:0]  op;
      cpu_addr_u   a;
      logic [63:0] ldata;
      logic        exp_h;
      logic [15:0] exp_d;
      for (int i = 0; i < RAND_COUNT; i++) begin
         r     = $urandom;
         pick  = $urandom % 100;
         ldata = {$urandom, $urandom};
         a = make_addr(TAG_BITS'({r[2:1], 4'h5}), `CACHE_LINE_BITS'(r[4:3]), r[6:5]);
         if (pick < 25) begin
            op = OP_FILL;
         end else if (pick < 45) begin
            op = OP_WRITE;
         end else if (pick < 97) begin
            op = OP_READ;
         end else begin
            op = OP_FLUSH;
         end
         predict_read(r[7], a, exp_h, exp_d);
         run_op($sformatf("random_%0d", i), op, r[7], a, r[31:16], ldata, exp_h, exp_d);
      end
   endtask

   initial begin
      clk_128 = 1'b0;
      forever begin
         #4 clk_128 = ~clk_128;
      end
   end

   // stop a hung run
   initial begin
      cycle_count = 0;
      while (cycle_count <= cycle_limit) begin
         @(posedge clk_128);
         cycle_count++;
      end
      $display("timeout: run still going after %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      void'($urandom(8067));
      error_count = 0;
      read_hits   = 0;
      read_misses = 0;
      arst_n      = 1'b0;
      clear_inputs();
      clear_model();
      load_vectors();
      cycle_limit = row_name.size() + RAND_COUNT + 100;

      repeat (4) @(posedge clk_128);
      #1;
      arst_n = 1'b1;

      // counters cleared by reset
      check_count("reset_hit_count", 0, hit_count);
      check_count("reset_miss_count", 0, miss_count);

      // every line misses in both spaces, no rd so the counters stay put
      for (int l = 0; l < LINE_COUNT; l++) begin
         @(posedge clk_128);
         #1;
         addr  = make_addr(TAG_BITS'(l), `CACHE_LINE_BITS'(l), 2'(l));
         space = 1'b0;
         #1;
         check_read($sformatf("reset_data_line_%0d", l), 1'b0, 16'h0000);
         space = 1'b1;
         #1;
         check_read($sformatf("reset_prog_line_%0d", l), 1'b0, 16'h0000);
      end

      for (int i = 0; i < row_name.size(); i++) begin
         run_op(row_name[i], row_op[i], row_space[i], row_addr[i],
                row_din[i], row_din64[i], row_hit[i], row_dout[i]);
      end

      run_random_traffic();

      // the last strobe is taken at this edge
      drive_idle();
      check_count("hit_count", read_hits, hit_count);
      check_count("miss_count", read_misses, miss_count);

      $display("errors: %0d  read hits: %0d  read misses: %0d",
               error_count, read_hits, read_misses);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
// cache package: derived sizes, cpu address union and cache line union
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

   // tag takes whatever is left above the line and word fields
   localparam int TAG_BITS = `CACHE_ADDR_BITS - `CACHE_LINE_BITS - 2;

   // lines per cache
   localparam int LINE_COUNT = 1 << `CACHE_LINE_BITS;

   // cpu word address
   // flat is what the cpu drives
   // field splits it into tag, line index and word select
   // word select is the low two bits, four 16-bit words per 64-bit line
   typedef union packed {
      logic [`CACHE_ADDR_BITS-1:0] flat;
      struct packed {
         logic [TAG_BITS-1:0]         tag;
         logic [`CACHE_LINE_BITS-1:0] line;
         logic [1:0]                  word;
      } field;
   } cpu_addr_u;

   // one cache line
   // flat is the 64-bit burst as memory returns it
   // word[0] sits in bits 15:0, word[3] in bits 63:48
   typedef union packed {
      logic [63:0]      flat;
      logic [3:0][15:0] word;
   } line_data_u;

endpackage

`default_nettype wire

// ==== verilog/cache_settings.svh ====
// size macros for the cpu read cache: address width, line index width, counter width
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cpu word address width
// the cpu drives 16-bit word addresses, so 23 bits span 16 MB of bytes
`define CACHE_ADDR_BITS 23

// number of line index bits per cache
// 5 gives 32 lines of 64 bits each
// 4 and 6 are also valid sizes, the tag field shrinks or grows to match
`define CACHE_LINE_BITS 5

// width of the host-visible hit and miss counters
// both counters stop at all ones
`define CACHE_COUNT_BITS 16

`endif

// ==== verilog/cache_steer.sv ====
// fill and write steering, result select and saturating hit/miss counters
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_steer (
   input  wire                          clk_128,
   input  wire                          arst_n,
   input  wire                          space,
   input  wire                          rd,
   input  wire                          wr,
   input  wire                          update64,
   input  wire                          inst_hit,
   input  wire [15:0]                   inst_dout,
   input  wire                          data_hit,
   input  wire [15:0]                   data_dout,
   output logic                         inst_fill,
   output logic                         data_fill,
   output logic                         write,
   output logic                         hit,
   output logic [15:0]                  dout,
   output logic [`CACHE_COUNT_BITS-1:0] hit_count,
   output logic [`CACHE_COUNT_BITS-1:0] miss_count
);

   // counter step that holds at all ones
   function automatic logic [`CACHE_COUNT_BITS-1:0] sat_inc(
      input logic [`CACHE_COUNT_BITS-1:0] value
   );
      if (&value) begin
         return value;
      end
      return value + `CACHE_COUNT_BITS'(1);
   endfunction

   // fill routing
   // space high is program space and goes to the instruction cache
   assign inst_fill = update64 && space;
   assign data_fill = update64 && !space;

   // cpu writes go to both caches
   // each one merges only where it already holds the line
   // so code rewritten through data space stays coherent in the instruction cache
   assign write = wr;

   // result of the cache for the active space
   assign hit  = space ? inst_hit  : data_hit;
   assign dout = space ? inst_dout : data_dout;

   // read statistics for the host
   // every rd strobe bumps exactly one of the two counters
   always_ff @(posedge clk_128 or negedge arst_n) begin
      if (!arst_n) begin
         hit_count  <= '0;
         miss_count <= '0;
      end else if (rd) begin
         if (hit) begin
            hit_count <= sat_inc(hit_count);
         end else begin
            miss_count <= sat_inc(miss_count);
         end
      end
   end

   // memory never returns a burst in the cycle the cpu writes
   // otherwise a fill and a write would meet in one cache
   a_fill_wr_excl : assert property (
      @(posedge clk_128) disable iff (!arst_n)
      !(update64 && wr)
   );

endmodule

`default_nettype wire

// ==== verilog/cpu_cache.sv ====
// cpu cache top: instruction cache, data cache and steering block
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cpu_cache (
   input  wire                          clk_128,
   input  wire                          arst_n,
   input  wire                          flush,
   input  wire cache_pkg::cpu_addr_u    addr,
   input  wire                          space,
   input  wire                          rd,
   input  wire                          wr,
   input  wire [15:0]                   din,
   input  wire [63:0]                   din64,
   input  wire                          update64,
   output wire [15:0]                   dout,
   output wire                          hit,
   output wire [`CACHE_COUNT_BITS-1:0]  hit_count,
   output wire [`CACHE_COUNT_BITS-1:0]  miss_count
);

   // per-cache fill strobes from the steering block
   wire        inst_fill;
   wire        data_fill;

   // shared write strobe
   wire        cache_write;

   // lookup results back to the steering block
   wire        inst_hit;
   wire [15:0] inst_dout;
   wire        data_hit;
   wire [15:0] data_dout;

   // program space cache
   line_cache inst_cache0 (
      .clk_128 (clk_128),
      .arst_n  (arst_n),
      .flush   (flush),
      .addr    (addr),
      .fill    (inst_fill),
      .write   (cache_write),
      .din     (din),
      .din64   (din64),
      .hit     (inst_hit),
      .dout    (inst_dout)
   );

   // data space cache
   line_cache data_cache0 (
      .clk_128 (clk_128),
      .arst_n  (arst_n),
      .flush   (flush),
      .addr    (addr),
      .fill    (data_fill),
      .write   (cache_write),
      .din     (din),
      .din64   (din64),
      .hit     (data_hit),
      .dout    (data_dout)
   );

   // routing, result select and counters
   cache_steer steer0 (
      .clk_128    (clk_128),
      .arst_n     (arst_n),
      .space      (space),
      .rd         (rd),
      .wr         (wr),
      .update64   (update64),
      .inst_hit   (inst_hit),
      .inst_dout  (inst_dout),
      .data_hit   (data_hit),
      .data_dout  (data_dout),
      .inst_fill  (inst_fill),
      .data_fill  (data_fill),
      .write      (cache_write),
      .hit        (hit),
      .dout       (dout),
      .hit_count  (hit_count),
      .miss_count (miss_count)
   );

endmodule

`default_nettype wire

// ==== verilog/line_cache.sv ====
// direct-mapped read cache with tag, valid and data arrays and word write merge
`timescale 1ns/100ps
`default_nettype none

module line_cache (
   input  wire                  clk_128,
   input  wire                  arst_n,
   input  wire                  flush,
   input  wire cache_pkg::cpu_addr_u addr,
   input  wire                  fill,
   input  wire                  write,
   input  wire [15:0]           din,
   input  wire [63:0]           din64,
   output logic                 hit,
   output logic [15:0]          dout
);

   import cache_pkg::*;

   // storage arrays
   // data and tag are plain ram, only the valid bits carry state that matters
   line_data_u          data_mem [LINE_COUNT];
   logic [TAG_BITS-1:0] tag_mem  [LINE_COUNT];
   logic [LINE_COUNT-1:0] valid;

   // line currently addressed by the cpu
   line_data_u cur_line;

   // cur_line with the cpu write word merged in
   line_data_u merged_line;

   // a fill only counts when no flush comes with it
   logic take_fill;

   // a write only lands on a line that hits
   logic take_write;

   assign cur_line = data_mem[addr.field.line];

   // lookup path, fully combinational
   // hit needs the valid bit and a matching tag on the indexed line
   assign hit = valid[addr.field.line] && (tag_mem[addr.field.line] == addr.field.tag);

   // word select through the line union
   assign dout = cur_line.word[addr.field.word];

   // flush beats a fill in the same cycle
   assign take_fill = fill && !flush;

   // write miss leaves the array alone
   assign take_write = write && hit;

   // replace just the addressed word, the other three stay as stored
   always_comb begin
      merged_line = cur_line;
      merged_line.word[addr.field.word] = din;
   end

   // data and tag arrays
   // a fill writes the whole burst and the new tag
   // a write hit rewrites the line with one word changed
   always_ff @(posedge clk_128) begin
      if (take_fill) begin
         data_mem[addr.field.line].flat <= din64;
         tag_mem[addr.field.line]       <= addr.field.tag;
      end else if (take_write) begin
         data_mem[addr.field.line] <= merged_line;
      end
   end

   // valid bits
   // reset and flush both drop every line
   // a fill marks just its own line
   always_ff @(posedge clk_128 or negedge arst_n) begin
      if (!arst_n) begin
         valid <= '0;
      end else if (flush) begin
         valid <= '0;
      end else if (take_fill) begin
         valid[addr.field.line] <= 1'b1;
      end
   end

   // the steering block must never raise a fill and a write in one cycle
   a_fill_write_excl : assert property (
      @(posedge clk_128) disable iff (!arst_n)
      !(fill && write)
   );

   // a fill is visible as a hit one cycle later at the same address
   // the tag, data and valid writes must all have landed together
   a_fill_then_hit : assert property (
      @(posedge clk_128) disable iff (!arst_n)
      take_fill ##1 $stable(addr.flat) |-> hit
   );

endmodule

`default_nettype wire
